// ==== test/dcache_testdata.txt ====
# op addr wdata strb expected refills, all hex except op and refills
# op 0 read, 1 write, 2 memory check; refills is the running total
# read miss then read hit, index 1
0 00001008 0000000000000000 00 5a5a4a525a5a4a52 1
0 00001008 0000000000000000 00 5a5a4a525a5a4a52 1
# strobed write hit on the low four bytes, then read back
1 00001008 1122334455667788 0f 0000000000000000 1
0 0000100c 0000000000000000 00 5a5a4a5255667788 1
# dirty eviction, index 2
1 00000010 deadbeefcafef00d ff 0000000000000000 2
0 00000210 0000000000000000 00 5a5a584a5a5a584a 3
0 00000410 0000000000000000 00 5a5a5e4a5a5a5e4a 4
2 00000010 0000000000000000 00 deadbeefcafef00d 4
0 00000010 0000000000000000 00 deadbeefcafef00d 5
# replacement order A B A C A, index 3
0 00000018 0000000000000000 00 5a5a5a425a5a5a42 6
0 00000218 0000000000000000 00 5a5a58425a5a5842 7
0 00000018 0000000000000000 00 5a5a5a425a5a5a42 7
0 00000418 0000000000000000 00 5a5a5e425a5a5e42 8
0 00000018 0000000000000000 00 5a5a5a425a5a5a42 8
# write miss allocates, index 4
1 00003020 0102030405060708 f0 0000000000000000 9
0 00003020 0000000000000000 00 010203045a5a6a7a 9

// ==== all.f ====
source/dcache_pkg.sv
source/dcache_array_if.sv
source/dcache_way.sv
source/dcache_ctrl.sv
source/dcache_top.sv
test/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb
    import dcache_pkg::*;
();

    logic               clk;
    logic               rst_n_i;
    logic               req_valid_i;
    logic               req_we_i;
    logic [ADDR_W-1:0]  req_addr_i;
    logic [DATA_W-1:0]  req_wdata_i;
    logic [STRB_W-1:0]  req_strb_i;
    logic               req_ready_o;
    logic               resp_valid_o;
    logic [DATA_W-1:0]  resp_rdata_o;
    logic               mem_req_o;
    logic               mem_we_o;
    logic [ADDR_W-1:0]  mem_addr_o;
    logic [DATA_W-1:0]  mem_wdata_o;
    logic               mem_ack_i;
    logic [DATA_W-1:0]  mem_rdata_i;

    // one entry per data line
    int                 op_q[$];
    logic [ADDR_W-1:0]  addr_q[$];
    logic [DATA_W-1:0]  wdata_q[$];
    logic [STRB_W-1:0]  strb_q[$];
    logic [DATA_W-1:0]  exp_q[$];
    int                 refill_q[$];

    logic [DATA_W-1:0]  mem_store [logic [ADDR_W-1:0]];
    int                 seed = 39682;
    int                 refill_count = 0;
    int                 prev_refills = 0;
    int                 test_count = 0;
    int                 pass_count = 0;
    int                 fail_count = 0;
    int                 cycle_count = 0;
    int                 cycle_limit = 1000;

    dcache_top dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_we_i     (req_we_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_strb_i   (req_strb_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: no progress after %0d cycles", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // unwritten words read as the address xor 5a5a5a5a in both halves
    function automatic logic [DATA_W-1:0] memory_word(input logic [ADDR_W-1:0] addr);
        logic [31:0] half;
        half = addr ^ 32'h5A5A_5A5A;
        if (mem_store.exists(addr)) begin
            return mem_store[addr];
        end
        return {half, half};
    endfunction

    // memory model, decides at the falling edge and answers at the rising edge
    initial begin
        logic            give_ack;
        logic [DATA_W-1:0] ack_data;
        logic            mem_busy;
        int              mem_wait;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        ack_data    = '0;
        mem_busy    = 1'b0;
        mem_wait    = 0;
        forever begin
            @(negedge clk);
            give_ack = 1'b0;
            if (mem_req_o && !mem_ack_i) begin
                if (!mem_busy) begin
                    mem_busy = 1'b1;
                    mem_wait = $random(seed) & 3;
                end
                if (mem_wait == 0) begin
                    give_ack = 1'b1;
                    mem_busy = 1'b0;
                    if (mem_we_o) begin
                        mem_store[mem_addr_o] = mem_wdata_o;
                    end else begin
                        ack_data = memory_word(mem_addr_o);
                        refill_count++;
                    end
                end else begin
                    mem_wait--;
                end
            end
            @(posedge clk);
            mem_ack_i   <= give_ack;
            mem_rdata_i <= ack_data;
        end
    end

    task automatic load_vectors();
        int                fd;
        int                n;
        int                op;
        int                refills;
        string             line;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] expected;
        fd = $fopen("test/dcache_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/dcache_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %h %h %h %h %d", op, addr, wdata, strb, expected,
                            refills);
                if (n == 6) begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    wdata_q.push_back(wdata);
                    strb_q.push_back(strb);
                    exp_q.push_back(expected);
                    refill_q.push_back(refills);
                end
            end
        end
        $fclose(fd);
    endtask

    // one core request, returns data and cycles from accept to response
    task automatic core_access(input logic we, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                               output logic [DATA_W-1:0] rdata, output int latency);
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_we_i    <= we;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        req_strb_i  <= strb;
        @(negedge clk);
        while (!req_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid_i <= 1'b0;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (!resp_valid_o);
        rdata = resp_rdata_o;
    endtask

    task automatic finish_test(input string name, input int errs);
        test_count++;
        if (errs == 0) begin
            pass_count++;
            $display("test %0d %s: ok", test_count, name);
        end else begin
            fail_count++;
            $display("test %0d %s: %0d errors", test_count, name, errs);
        end
    endtask

    task automatic check_reset_state();
        int errs;
        errs = 0;
        @(negedge clk);
        if (req_ready_o !== 1'b1) begin
            $display("Fail at %0t: req_ready_o got %b expected 1", $time, req_ready_o);
            errs++;
        end
        if (resp_valid_o !== 1'b0) begin
            $display("Fail at %0t: resp_valid_o got %b expected 0", $time, resp_valid_o);
            errs++;
        end
        if (mem_req_o !== 1'b0) begin
            $display("Fail at %0t: mem_req_o got %b expected 0", $time, mem_req_o);
            errs++;
        end
        finish_test("after reset", errs);
    endtask

    task automatic run_vector(input int i);
        logic [DATA_W-1:0] rdata;
        logic [DATA_W-1:0] word;
        int                latency;
        int                errs;
        string             name;
        errs = 0;
        if (op_q[i] == 2) begin
            name = $sformatf("memory check %h", addr_q[i]);
            word = memory_word(addr_q[i]);
            if (word !== exp_q[i]) begin
                $display("Fail at %0t: memory word at %h got %h expected %h", $time,
                         addr_q[i], word, exp_q[i]);
                errs++;
            end
        end else begin
            if (op_q[i] == 1) begin
                name = $sformatf("write %h", addr_q[i]);
            end else begin
                name = $sformatf("read %h", addr_q[i]);
            end
            core_access(op_q[i] == 1, addr_q[i], wdata_q[i], strb_q[i], rdata, latency);
            if (op_q[i] == 0 && rdata !== exp_q[i]) begin
                $display("Fail at %0t: resp_rdata_o got %h expected %h", $time, rdata,
                         exp_q[i]);
                errs++;
            end
            // no new refill means a hit, which answers in two cycles
            if (refill_q[i] == prev_refills && latency != 2) begin
                $display("Fail at %0t: resp_valid_o latency got %0d expected 2", $time,
                         latency);
                errs++;
            end
        end
        if (refill_count != refill_q[i]) begin
            $display("Fail at %0t: refill count got %0d expected %0d", $time,
                     refill_count, refill_q[i]);
            errs++;
        end
        prev_refills = refill_q[i];
        finish_test(name, errs);
    endtask

    initial begin
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_we_i    = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_strb_i  = '0;
        load_vectors();
        cycle_limit = (op_q.size() + 1) * 40;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        check_reset_state();
        if (op_q.size() == 0) begin
            $display("no test vectors were read from the data file");
            fail_count++;
        end else begin
            for (int i = 0; i < op_q.size(); i++) begin
                run_vector(i);
            end
        end
        $display("%0d tests, %0d passed, %0d failed", test_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    // core side
    input  logic               req_valid_i,
    input  logic               req_we_i,
    input  logic [ADDR_W-1:0]  req_addr_i,
    input  logic [DATA_W-1:0]  req_wdata_i,
    input  logic [STRB_W-1:0]  req_strb_i,
    output logic               req_ready_o,
    output logic               resp_valid_o,
    output logic [DATA_W-1:0]  resp_rdata_o,
    // memory side
    output logic               mem_req_o,
    output logic               mem_we_o,
    output logic [ADDR_W-1:0]  mem_addr_o,
    output logic [DATA_W-1:0]  mem_wdata_o,
    input  logic               mem_ack_i,
    input  logic [DATA_W-1:0]  mem_rdata_i
);

    logic [TAG_W-1:0]  way_tag  [2];
    logic [1:0]        way_valid;
    logic [1:0]        way_dirty;
    logic [DATA_W-1:0] way_data [2];

    dcache_array_if arr_if ();

    dcache_ctrl ctrl0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_we_i     (req_we_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_strb_i   (req_strb_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i),
        .arr_if       (arr_if.ctrl),
        .way_tag_i    (way_tag),
        .way_valid_i  (way_valid),
        .way_dirty_i  (way_dirty),
        .way_data_i   (way_data)
    );

    dcache_way way0 (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .arr_if    (arr_if.way),
        .way_sel_i (1'b0),
        .tag_o     (way_tag[0]),
        .valid_o   (way_valid[0]),
        .dirty_o   (way_dirty[0]),
        .data_o    (way_data[0])
    );

    dcache_way way1 (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .arr_if    (arr_if.way),
        .way_sel_i (1'b1),
        .tag_o     (way_tag[1]),
        .valid_o   (way_valid[1]),
        .dirty_o   (way_dirty[1]),
        .data_o    (way_data[1])
    );

endmodule

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    // core side
    input  logic               req_valid_i,
    input  logic               req_we_i,
    input  logic [ADDR_W-1:0]  req_addr_i,
    input  logic [DATA_W-1:0]  req_wdata_i,
    input  logic [STRB_W-1:0]  req_strb_i,
    output logic               req_ready_o,
    output logic               resp_valid_o,
    output logic [DATA_W-1:0]  resp_rdata_o,
    // memory side
    output logic               mem_req_o,
    output logic               mem_we_o,
    output logic [ADDR_W-1:0]  mem_addr_o,
    output logic [DATA_W-1:0]  mem_wdata_o,
    input  logic               mem_ack_i,
    input  logic [DATA_W-1:0]  mem_rdata_i,
    // way arrays
    dcache_array_if.ctrl       arr_if,
    input  logic [TAG_W-1:0]   way_tag_i  [2],
    input  logic [1:0]         way_valid_i,
    input  logic [1:0]         way_dirty_i,
    input  logic [DATA_W-1:0]  way_data_i [2]
);

    ctrl_state_e        state_q;
    ctrl_state_e        state_d;
    dcache_addr_u       req_q;
    logic               we_q;
    logic [DATA_W-1:0]  wdata_q;
    logic [STRB_W-1:0]  strb_q;
    logic [SETS-1:0]    lru_q;
    logic               victim_q;
    logic [1:0]         hit_vec;
    logic               hit;
    logic               hit_way;
    logic               victim;
    dcache_addr_u       wb_addr;
    dcache_addr_u       fill_addr;

    assign req_ready_o = (state_q == IDLE);

    // hit detect against both stored tags
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_vec[w] = way_valid_i[w] && (way_tag_i[w] == req_q.fields.tag);
        end
    end
    assign hit     = |hit_vec;
    assign hit_way = hit_vec[1];

    // invalid way first, way 0 before way 1, then the lru way
    assign victim = !way_valid_i[0] ? 1'b0 :
                    !way_valid_i[1] ? 1'b1 : lru_q[req_q.fields.index];

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:      if (req_valid_i) state_d = LOOKUP;
            LOOKUP:    state_d = HIT;
            HIT: begin
                if (hit) begin
                    state_d = IDLE;
                end else if (way_valid_i[victim] && way_dirty_i[victim]) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            WRITEBACK: if (mem_ack_i) state_d = REFILL;
            REFILL:    if (mem_ack_i) state_d = LOOKUP;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            lru_q    <= '0;
            victim_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == HIT && hit) begin
                lru_q[req_q.fields.index] <= ~hit_way;
            end
            if (state_q == HIT && !hit) begin
                victim_q <= victim;
            end
        end
    end

    // accepted request
    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_q.raw <= req_addr_i;
            we_q      <= req_we_i;
            wdata_q   <= req_wdata_i;
            strb_q    <= req_strb_i;
        end
    end

    assign resp_valid_o = (state_q == HIT) && hit;
    assign resp_rdata_o = way_data_i[hit_way];

    // array requests: strobed write on hit, full-line fill on refill
    always_comb begin
        arr_if.addr      = req_q;
        arr_if.we        = 2'b00;
        arr_if.strb      = '0;
        arr_if.wdata     = wdata_q;
        arr_if.set_dirty = 1'b0;
        arr_if.clr_dirty = 1'b0;
        if (state_q == HIT && hit && we_q) begin
            arr_if.we[hit_way] = 1'b1;
            arr_if.strb        = strb_q;
            arr_if.set_dirty   = 1'b1;
        end else if (state_q == REFILL && mem_ack_i) begin
            arr_if.we[victim_q] = 1'b1;
            arr_if.strb         = '1;
            arr_if.wdata        = mem_rdata_i;
            arr_if.clr_dirty    = 1'b1;
        end
    end

    // victim line address rebuilt from its stored tag
    always_comb begin
        wb_addr.fields.tag    = way_tag_i[victim_q];
        wb_addr.fields.index  = req_q.fields.index;
        wb_addr.fields.offset = '0;
        fill_addr             = req_q;
        fill_addr.fields.offset = '0;
    end

    assign mem_req_o   = (state_q == WRITEBACK) || (state_q == REFILL);
    assign mem_we_o    = (state_q == WRITEBACK);
    assign mem_addr_o  = (state_q == WRITEBACK) ? wb_addr.raw : fill_addr.raw;
    assign mem_wdata_o = (state_q == WRITEBACK) ? way_data_i[victim_q] : '0;

    // request held with stable fields until memory acks
    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_we_o)
            && $stable(mem_addr_o) && $stable(mem_wdata_o));

    // a line never sits in both ways of one set
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        state_q == HIT |-> $onehot0(hit_vec));

endmodule

// ==== source/dcache_way.sv ====
`timescale 1ns/100ps

module dcache_way
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    dcache_array_if.way        arr_if,
    input  logic               way_sel_i,
    output logic [TAG_W-1:0]   tag_o,
    output logic               valid_o,
    output logic               dirty_o,
    output logic [DATA_W-1:0]  data_o
);

    logic [TAG_W-1:0]   tag_mem  [SETS];
    logic [DATA_W-1:0]  data_mem [SETS];
    logic [SETS-1:0]    valid_q;
    logic [SETS-1:0]    dirty_q;
    logic [INDEX_W-1:0] idx;
    logic               we;

    assign idx = arr_if.addr.fields.index;
    assign we  = arr_if.we[way_sel_i];

    // per-set state bits
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (we) begin
            valid_q[idx] <= 1'b1;
            if (arr_if.set_dirty) begin
                dirty_q[idx] <= 1'b1;
            end else if (arr_if.clr_dirty) begin
                dirty_q[idx] <= 1'b0;
            end
        end
    end

    // tag and byte-strobed data storage
    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[idx] <= arr_if.addr.fields.tag;
            for (int b = 0; b < STRB_W; b++) begin
                if (arr_if.strb[b]) begin
                    data_mem[idx][b*8 +: 8] <= arr_if.wdata[b*8 +: 8];
                end
            end
        end
    end

    // registered read port
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            dirty_o <= 1'b0;
        end else begin
            valid_o <= valid_q[idx];
            dirty_o <= dirty_q[idx];
        end
    end

    always_ff @(posedge clk) begin
        tag_o  <= tag_mem[idx];
        data_o <= data_mem[idx];
    end

    // controller must never ask for both dirty updates at once
    a_dirty_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(arr_if.set_dirty && arr_if.clr_dirty));

endmodule

// ==== source/dcache_array_if.sv ====
`timescale 1ns/100ps

interface dcache_array_if
    import dcache_pkg::*;
();

    // lookup index and tag to write, shared by both ways
    dcache_addr_u      addr;
    // one write enable per way
    logic [1:0]        we;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] wdata;
    logic              set_dirty;
    logic              clr_dirty;

    modport ctrl (
        output addr,
        output we,
        output strb,
        output wdata,
        output set_dirty,
        output clr_dirty
    );

    modport way (
        input addr,
        input we,
        input strb,
        input wdata,
        input set_dirty,
        input clr_dirty
    );

endinterface

// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    // geometry
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 64;
    localparam int STRB_W   = DATA_W / 8;
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int SETS     = 1 << INDEX_W;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // one address word, seen raw or split into its cache fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } fields;
    } dcache_addr_u;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        // compare stage, also where a miss is detected
        HIT,
        WRITEBACK,
        REFILL
    } ctrl_state_e;

endpackage
